/* rtl/systolic_array_pkg.sv */
package systolic_array_pkg;

    //////////////////////////////////////////////////////////////////////
    // Mesh geometry
    //////////////////////////////////////////////////////////////////////

    // Side of the square PE mesh
    localparam int ARRAY_SIZE = 4;

    // Default element width carried on every lane
    localparam int ELEM_WIDTH = 8;

    //////////////////////////////////////////////////////////////////////
    // Lane types
    //////////////////////////////////////////////////////////////////////

    // One matrix element
    typedef logic [ELEM_WIDTH-1:0] elem_t;

    // One element per lane, lane 0 in the low bits
    // Used for memory words, skewed operands and C columns alike
    typedef logic [ARRAY_SIZE*$bits(elem_t)-1:0] lane_vec_t;

endpackage

/* rtl/matmul_schedule_pkg.sv */
package matmul_schedule_pkg;

    import systolic_array_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Address and counter widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH   = 10;
    localparam int STRIDE_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [STRIDE_WIDTH-1:0] stride_t;

    // Wide enough for one full multiplication with plenty of margin
    typedef logic [7:0] cycle_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // Schedule of one multiplication
    //////////////////////////////////////////////////////////////////////

    // Input flops, product register and accumulator
    localparam int MAC_STAGES = 3;

    // Registered read on both operand memories
    localparam int MEM_LATENCY = 1;

    // Last operand pair reaches the far corner PE after 3N-1 cycles,
    // then it still has to drain through the MAC pipeline
    localparam cycle_cnt_t LATCH_CYCLE = cycle_cnt_t'(3 * ARRAY_SIZE - 1 + MAC_STAGES);

    // Four columns leave the capture unit before done is raised
    localparam cycle_cnt_t DONE_CYCLE = cycle_cnt_t'(LATCH_CYCLE + MAC_STAGES);

endpackage

/* rtl/matmul_sequencer.sv */
`timescale 1ns/1ps

module matmul_sequencer
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_mat_mul,
    output cycle_cnt_t clk_cnt,
    output logic       done_mat_mul
);

    //////////////////////////////////////////////////////////////////////
    // Cycle counter and done pulse
    //////////////////////////////////////////////////////////////////////

    // The count runs for as long as start is held high.
    // done is high only in the cycle that follows the DONE_CYCLE edge
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt      <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            clk_cnt      <= clk_cnt + 1'b1;
            done_mat_mul <= (clk_cnt == DONE_CYCLE);
        end
    end

endmodule

/* rtl/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
#(
    parameter int DATA_WIDTH = ELEM_WIDTH
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_mat_mul,
    input  cycle_cnt_t clk_cnt,
    input  addr_t      base_addr,
    input  stride_t    stride,
    input  lane_vec_t  mem_data,
    output addr_t      mem_addr,
    output lane_vec_t  skewed_lanes
);

    logic                  in_window;
    logic                  mem_access;
    cycle_cnt_t            access_cnt;
    logic                  data_valid;
    logic [DATA_WIDTH-1:0] lane_in   [ARRAY_SIZE];
    logic [DATA_WIDTH-1:0] lane_tail [ARRAY_SIZE];

    //////////////////////////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////////////////////////

    // One word per edge while the count is inside the fetch window
    assign in_window = (clk_cnt < cycle_cnt_t'(ARRAY_SIZE));

    // Parked one stride below the base so the first step lands on it
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !in_window)
        begin
            mem_addr   <= base_addr - addr_t'(stride);
            mem_access <= 1'b0;
        end
        else
        begin
            mem_addr   <= mem_addr + addr_t'(stride);
            mem_access <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Valid qualification
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !mem_access)
            access_cnt <= '0;
        else
            access_cnt <= access_cnt + 1'b1;
    end

    // Read data trails the address by the memory latency
    assign data_valid = (access_cnt >= cycle_cnt_t'(MEM_LATENCY));

    always_comb
    begin
        for (int i = 0; i < ARRAY_SIZE; i++)
            lane_in[i] = data_valid ? mem_data[i*DATA_WIDTH +: DATA_WIDTH] : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Systolic skew, lane i is delayed by i cycles
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_lane
        if (i == 0)
        begin : g_direct
            assign lane_tail[i] = lane_in[i];
        end
        else
        begin : g_delay
            logic [DATA_WIDTH-1:0] stage [i];

            // Cleared at count 0 so nothing stale enters the mesh
            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul || clk_cnt == '0)
                begin
                    for (int s = 0; s < i; s++)
                        stage[s] <= '0;
                end
                else
                begin
                    stage[0] <= lane_in[i];
                    for (int s = 1; s < i; s++)
                        stage[s] <= stage[s-1];
                end
            end

            assign lane_tail[i] = stage[i-1];
        end
    end

    always_comb
    begin
        for (int i = 0; i < ARRAY_SIZE; i++)
            skewed_lanes[i*DATA_WIDTH +: DATA_WIDTH] = lane_tail[i];
    end

endmodule

/* rtl/processing_element.sv */
`timescale 1ns/1ps

module processing_element #(
    parameter int DATA_WIDTH = 8
)
(
    input  logic                  clk,
    input  logic                  clear,
    input  logic [DATA_WIDTH-1:0] in_a,
    input  logic [DATA_WIDTH-1:0] in_b,
    output logic [DATA_WIDTH-1:0] out_a,
    output logic [DATA_WIDTH-1:0] out_b,
    output logic [DATA_WIDTH-1:0] acc
);

    logic [DATA_WIDTH-1:0] a_q;
    logic [DATA_WIDTH-1:0] b_q;
    logic [DATA_WIDTH-1:0] product;

    // Operands move one cell right and one cell down per cycle
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a <= '0;
            out_b <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Three-stage MAC, everything wraps at DATA_WIDTH bits
    //////////////////////////////////////////////////////////////////////

    // The accumulator adds every cycle, so the pipeline must hold zeros
    // whenever no operands are flowing
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            a_q     <= '0;
            b_q     <= '0;
            product <= '0;
            acc     <= '0;
        end
        else
        begin
            a_q     <= in_a;
            b_q     <= in_b;
            product <= a_q * b_q;
            acc     <= acc + product;
        end
    end

endmodule

/* rtl/pe_array.sv */
`timescale 1ns/1ps

module pe_array
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
#(
    parameter int DATA_WIDTH = ELEM_WIDTH
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           pe_reset,
    input  lane_vec_t      row_operands,
    input  lane_vec_t      col_operands,
    output wire lane_vec_t result_cols [ARRAY_SIZE]
);

    // Accumulators survive start_mat_mul so successive products add up
    logic pe_clear;

    // a_link[i][j] feeds PE(i,j) from the left, b_link[i][j] from above.
    // The extra column and row take the far-edge outputs and end there
    wire [DATA_WIDTH-1:0] a_link [ARRAY_SIZE][ARRAY_SIZE+1];
    wire [DATA_WIDTH-1:0] b_link [ARRAY_SIZE+1][ARRAY_SIZE];

    assign pe_clear = reset | pe_reset;

    //////////////////////////////////////////////////////////////////////
    // Mesh edges
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < ARRAY_SIZE; k++)
    begin : g_edge
        assign a_link[k][0] = row_operands[k*DATA_WIDTH +: DATA_WIDTH];
        assign b_link[0][k] = col_operands[k*DATA_WIDTH +: DATA_WIDTH];
    end

    //////////////////////////////////////////////////////////////////////
    // 4x4 mesh
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < ARRAY_SIZE; j++)
        begin : g_col
            // Row i of the accumulators becomes lane i of column j
            processing_element #(
                .DATA_WIDTH (DATA_WIDTH)
            )
            u_pe (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (result_cols[j][i*DATA_WIDTH +: DATA_WIDTH])
            );
        end
    end

endmodule

/* rtl/output_capture.sv */
`timescale 1ns/1ps

module output_capture
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
#(
    parameter int DATA_WIDTH = ELEM_WIDTH
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_mat_mul,
    input  logic       done_mat_mul,
    input  cycle_cnt_t clk_cnt,
    input  lane_vec_t  result_cols [ARRAY_SIZE],
    input  addr_t      base_addr,
    input  stride_t    stride,
    output lane_vec_t  c_data_out,
    output addr_t      c_addr,
    output logic       c_data_available
);

    localparam int COUNT_WIDTH = $clog2(ARRAY_SIZE + 1);

    logic                   latch_en;
    logic                   capture_active;
    logic [COUNT_WIDTH-1:0] col_count;
    lane_vec_t              pending_cols [ARRAY_SIZE-1];

    // All accumulators are final one edge before this count
    assign latch_en = (clk_cnt == LATCH_CYCLE);

    //////////////////////////////////////////////////////////////////////
    // Column latch and shift-out
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || done_mat_mul)
        begin
            capture_active   <= 1'b0;
            c_data_available <= 1'b0;
            c_addr           <= base_addr;
            c_data_out       <= '0;
            col_count        <= '0;
            for (int k = 0; k < ARRAY_SIZE - 1; k++)
                pending_cols[k] <= '0;
        end
        else if (latch_en)
        begin
            // Column 0 goes out at once, the rest wait in the chain
            capture_active   <= 1'b1;
            c_data_available <= 1'b1;
            c_addr           <= base_addr;
            c_data_out       <= result_cols[0];
            col_count        <= COUNT_WIDTH'(1);
            for (int k = 0; k < ARRAY_SIZE - 1; k++)
                pending_cols[k] <= result_cols[k+1];
        end
        else if (capture_active)
        begin
            if (col_count < COUNT_WIDTH'(ARRAY_SIZE))
            begin
                c_addr     <= c_addr + addr_t'(stride);
                c_data_out <= pending_cols[0];
                col_count  <= col_count + 1'b1;
                for (int k = 0; k < ARRAY_SIZE - 2; k++)
                    pending_cols[k] <= pending_cols[k+1];
                pending_cols[ARRAY_SIZE-2] <= '0;
            end
            else
            begin
                // Only reached if done is late, all columns are out
                capture_active   <= 1'b0;
                c_data_available <= 1'b0;
                c_data_out       <= '0;
            end
        end
    end

endmodule

/* rtl/matmul_4x4_systolic.sv */
`timescale 1ns/1ps

module matmul_4x4_systolic
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
#(
    parameter int DATA_WIDTH = ELEM_WIDTH
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pe_reset,
    input  logic      start_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  lane_vec_t a_data,
    input  lane_vec_t b_data,
    output addr_t     a_addr,
    output addr_t     b_addr,
    output addr_t     c_addr,
    output lane_vec_t c_data_out,
    output logic      c_data_available,
    output logic      done_mat_mul
);

    cycle_cnt_t clk_cnt;
    lane_vec_t  a_skewed;
    lane_vec_t  b_skewed;
    lane_vec_t  result_cols [ARRAY_SIZE];

    //////////////////////////////////////////////////////////////////////
    // Control and operand streams
    //////////////////////////////////////////////////////////////////////

    matmul_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .done_mat_mul  (done_mat_mul)
    );

    // Columns of A enter the mesh from the left
    operand_fetch #(
        .DATA_WIDTH (DATA_WIDTH)
    )
    u_fetch_a (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .base_addr     (address_mat_a),
        .stride        (address_stride_a),
        .mem_data      (a_data),
        .mem_addr      (a_addr),
        .skewed_lanes  (a_skewed)
    );

    // Rows of B enter the mesh from the top
    operand_fetch #(
        .DATA_WIDTH (DATA_WIDTH)
    )
    u_fetch_b (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .base_addr     (address_mat_b),
        .stride        (address_stride_b),
        .mem_data      (b_data),
        .mem_addr      (b_addr),
        .skewed_lanes  (b_skewed)
    );

    //////////////////////////////////////////////////////////////////////
    // Mesh and result path
    //////////////////////////////////////////////////////////////////////

    pe_array #(
        .DATA_WIDTH (DATA_WIDTH)
    )
    u_pe_array (
        .clk          (clk),
        .reset        (reset),
        .pe_reset     (pe_reset),
        .row_operands (a_skewed),
        .col_operands (b_skewed),
        .result_cols  (result_cols)
    );

    output_capture #(
        .DATA_WIDTH (DATA_WIDTH)
    )
    u_output_capture (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .done_mat_mul     (done_mat_mul),
        .clk_cnt          (clk_cnt),
        .result_cols      (result_cols),
        .base_addr        (address_mat_c),
        .stride           (address_stride_c),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

/* verification/matmul_assertions.sv */
`timescale 1ns/1ps

module matmul_assertions (
    input logic clk,
    input logic reset,
    input logic start_mat_mul,
    input logic done_mat_mul,
    input logic c_data_available
);

    // Read by the testbench at the end of the run
    int failure_count = 0;

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul)
    else
    begin
        failure_count++;
        $error("done_mat_mul stayed high for more than one cycle");
    end

    // Columns are only offered while the multiplication is still requested
    available_needs_start: assert property (@(posedge clk) disable iff (reset)
        c_data_available |-> start_mat_mul)
    else
    begin
        failure_count++;
        $error("c_data_available was high without start_mat_mul");
    end

    reset_clears_outputs: assert property (@(posedge clk)
        reset |=> (!done_mat_mul && !c_data_available))
    else
    begin
        failure_count++;
        $error("done or available high in the cycle after reset");
    end

endmodule

bind matmul_4x4_systolic matmul_assertions u_assertions (
    .clk              (clk),
    .reset            (reset),
    .start_mat_mul    (start_mat_mul),
    .done_mat_mul     (done_mat_mul),
    .c_data_available (c_data_available)
);

/* verification/matmul_tb.sv */
`timescale 1ns/1ps

module matmul_tb
    import systolic_array_pkg::*;
    import matmul_schedule_pkg::*;
();

    // Five tests of roughly 20 to 60 cycles each, with margin
    localparam int TIMEOUT_CYCLES    = 400;
    localparam int FIRST_COLUMN_EDGE = int'(LATCH_CYCLE) + 1;
    localparam int DONE_EDGE         = int'(DONE_CYCLE) + 1;

    logic        clk = 1'b0;
    logic        reset;
    logic        pe_reset;
    logic        start_mat_mul;
    addr_t       address_mat_a;
    addr_t       address_mat_b;
    addr_t       address_mat_c;
    stride_t     address_stride_a;
    stride_t     address_stride_b;
    stride_t     address_stride_c;
    lane_vec_t   a_data = '0;
    lane_vec_t   b_data = '0;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    lane_vec_t   c_data_out;
    logic        c_data_available;
    logic        done_mat_mul;

    lane_vec_t   mem_a [addr_t];
    lane_vec_t   mem_b [addr_t];
    elem_t       mat_a     [ARRAY_SIZE][ARRAY_SIZE];
    elem_t       mat_b     [ARRAY_SIZE][ARRAY_SIZE];
    elem_t       acc_model [ARRAY_SIZE][ARRAY_SIZE];
    logic [16:0] lfsr_state;
    int          cycle_count = 0;
    int          error_count;
    int          test_count;
    int          first_column_edge;
    int          done_edge;
    int          column_cycles;

    matmul_4x4_systolic #(
        .DATA_WIDTH (ELEM_WIDTH)
    )
    i_matmul_4x4_systolic (
        .clk              (clk),
        .reset            (reset),
        .pe_reset         (pe_reset),
        .start_mat_mul    (start_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available),
        .done_mat_mul     (done_mat_mul)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // Operand memories with a registered read, one cycle of latency
    always @(posedge clk)
    begin
        a_data <= #1 mem_a.exists(a_addr) ? mem_a[a_addr] : '0;
        b_data <= #1 mem_b.exists(b_addr) ? mem_b[b_addr] : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic feedback;
        feedback = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], feedback};
        return feedback;
    endfunction

    function automatic elem_t random_elem();
        elem_t value;
        value = '0;
        for (int n = 0; n < $bits(elem_t); n++)
            value = {value[$bits(elem_t)-2:0], lfsr_bit()};
        return value;
    endfunction

    function automatic addr_t strided_addr(input addr_t base, input stride_t stride,
                                           input int step);
        return base + addr_t'(stride) * addr_t'(step);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input string what, input int expected,
                               input int actual);
        assert (expected == actual)
        else
        begin
            error_count++;
            $display("error %s: %s expected %0h actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    // Reset clears the PE accumulators as well
    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) next_cycle();
        reset = 1'b0;
        for (int i = 0; i < ARRAY_SIZE; i++)
            for (int j = 0; j < ARRAY_SIZE; j++)
                acc_model[i][j] = '0;
    endtask

    task automatic clear_accumulators();
        pe_reset = 1'b1;
        next_cycle();
        pe_reset = 1'b0;
        for (int i = 0; i < ARRAY_SIZE; i++)
            for (int j = 0; j < ARRAY_SIZE; j++)
                acc_model[i][j] = '0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                mat_a[i][k] = random_elem();
                mat_b[i][k] = random_elem();
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One multiplication, checked against the reference accumulators
    //////////////////////////////////////////////////////////////////////

    task automatic run_matmul(input string name, input addr_t base_a, input stride_t stride_a,
                              input addr_t base_b, input stride_t stride_b,
                              input addr_t base_c, input stride_t stride_c);
        lane_vec_t word_a;
        lane_vec_t word_b;
        elem_t     sum;
        int        edges;
        mem_a.delete();
        mem_b.delete();
        // Word k of A is column k, word k of B is row k
        for (int k = 0; k < ARRAY_SIZE; k++)
        begin
            for (int n = 0; n < ARRAY_SIZE; n++)
            begin
                word_a[n*ELEM_WIDTH +: ELEM_WIDTH] = mat_a[n][k];
                word_b[n*ELEM_WIDTH +: ELEM_WIDTH] = mat_b[k][n];
            end
            mem_a[strided_addr(base_a, stride_a, k)] = word_a;
            mem_b[strided_addr(base_b, stride_b, k)] = word_b;
        end
        // The 8-bit sum wraps modulo 256 like the accumulators
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int j = 0; j < ARRAY_SIZE; j++)
            begin
                sum = acc_model[i][j];
                for (int k = 0; k < ARRAY_SIZE; k++)
                    sum = sum + mat_a[i][k] * mat_b[k][j];
                acc_model[i][j] = sum;
            end
        end

        // The fetch units park on the new bases before start rises
        address_mat_a    = base_a;
        address_mat_b    = base_b;
        address_mat_c    = base_c;
        address_stride_a = stride_a;
        address_stride_b = stride_b;
        address_stride_c = stride_c;
        next_cycle();
        start_mat_mul     = 1'b1;
        edges             = 0;
        first_column_edge = 0;
        done_edge         = 0;
        column_cycles     = 0;
        while (done_edge == 0 && edges < 2 * DONE_EDGE)
        begin
            next_cycle();
            edges++;
            if (edges <= ARRAY_SIZE)
            begin
                check_value(name, "a_addr", strided_addr(base_a, stride_a, edges - 1), a_addr);
                check_value(name, "b_addr", strided_addr(base_b, stride_b, edges - 1), b_addr);
            end
            if (c_data_available)
            begin
                if (first_column_edge == 0)
                    first_column_edge = edges;
                if (column_cycles < ARRAY_SIZE)
                begin
                    check_value(name, "c_addr",
                                strided_addr(base_c, stride_c, column_cycles), c_addr);
                    for (int i = 0; i < ARRAY_SIZE; i++)
                        check_value(name, $sformatf("C[%0d][%0d]", i, column_cycles),
                                    acc_model[i][column_cycles],
                                    c_data_out[i*ELEM_WIDTH +: ELEM_WIDTH]);
                end
                column_cycles++;
            end
            if (done_mat_mul)
                done_edge = edges;
        end
        assert (done_edge != 0)
        else
        begin
            error_count++;
            $display("%s: done_mat_mul did not arrive within %0d cycles", name, 2 * DONE_EDGE);
        end
        check_value(name, "available cycles", ARRAY_SIZE, column_cycles);

        // Start is still high, so done must drop by itself
        next_cycle();
        check_value(name, "done after pulse", 0, done_mat_mul);
        check_value(name, "available after done", 0, c_data_available);
        start_mat_mul = 1'b0;
        next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic identity_product();
        int errors_before;
        errors_before = error_count;
        clear_accumulators();
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                mat_a[i][k] = (i == k) ? elem_t'(1) : elem_t'(0);
                mat_b[i][k] = elem_t'(16 * i + k + 1);
            end
        end
        run_matmul("identity", 10'h000, 8'd1, 10'h040, 8'd1, 10'h080, 8'd1);
        report_test("identity", errors_before);
    endtask

    task automatic strided_random_product();
        int errors_before;
        errors_before = error_count;
        clear_accumulators();
        fill_random();
        // The C addresses wrap past the top of the 10-bit space
        run_matmul("random_strided", 10'h123, 8'd3, 10'h2c0, 8'd7, 10'h3f6, 8'd5);
        report_test("random_strided", errors_before);
    endtask

    task automatic wrapping_product();
        int errors_before;
        errors_before = error_count;
        clear_accumulators();
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                mat_a[i][k] = elem_t'(255 - i - k);
                mat_b[i][k] = elem_t'(8'hf0 + 4 * i + k);
            end
        end
        run_matmul("large_values", 10'h200, 8'd2, 10'h300, 8'd4, 10'h010, 8'd16);
        report_test("large_values", errors_before);
    endtask

    task automatic accumulation_across_runs();
        int errors_before;
        errors_before = error_count;
        clear_accumulators();
        fill_random();
        run_matmul("accumulate_first", 10'h010, 8'd1, 10'h020, 8'd1, 10'h030, 8'd1);
        fill_random();
        run_matmul("accumulate_second", 10'h050, 8'd2, 10'h070, 8'd3, 10'h090, 8'd4);
        clear_accumulators();
        fill_random();
        run_matmul("accumulate_cleared", 10'h0a0, 8'd1, 10'h0c0, 8'd1, 10'h0e0, 8'd1);
        report_test("accumulation", errors_before);
    endtask

    task automatic control_timing();
        int errors_before;
        int edges;
        errors_before = error_count;

        fill_random();
        run_matmul("control", 10'h100, 8'd1, 10'h180, 8'd2, 10'h1c0, 8'd1);
        check_value("control", "first column edge", FIRST_COLUMN_EDGE, first_column_edge);
        check_value("control", "done edge", DONE_EDGE, done_edge);

        // Reset while the columns are being shifted out, start stays high
        start_mat_mul = 1'b1;
        edges         = 0;
        while (!c_data_available && edges < 2 * DONE_EDGE)
        begin
            next_cycle();
            edges++;
        end
        assert (c_data_available)
        else
        begin
            error_count++;
            $display("control: c_data_available never rose before the reset");
        end
        apply_reset();
        check_value("control", "done after reset", 0, done_mat_mul);
        check_value("control", "available after reset", 0, c_data_available);
        check_value("control", "c_data_out after reset", 0, c_data_out);
        start_mat_mul = 1'b0;
        next_cycle();

        // Drop start while the mesh is still computing
        start_mat_mul = 1'b1;
        repeat (FIRST_COLUMN_EDGE / 2) next_cycle();
        start_mat_mul = 1'b0;
        repeat (DONE_EDGE)
        begin
            next_cycle();
            check_value("control", "done after abort", 0, done_mat_mul);
            check_value("control", "available after abort", 0, c_data_available);
        end
        report_test("control", errors_before);
    endtask

    initial
    begin
        reset            = 1'b1;
        pe_reset         = 1'b0;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        lfsr_state       = 17'd66824;
        error_count      = 0;
        test_count       = 0;
        apply_reset();

        identity_product();
        strided_random_product();
        wrapping_product();
        accumulation_across_runs();
        control_timing();

        // Bound assertion failures count as failed checks too
        error_count = error_count + i_matmul_4x4_systolic.u_assertions.failure_count;
        $display("tests run %0d, checks failed %0d", test_count, error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* matmul_4x4_systolic.f */
rtl/systolic_array_pkg.sv
rtl/matmul_schedule_pkg.sv
rtl/matmul_sequencer.sv
rtl/operand_fetch.sv
rtl/processing_element.sv
rtl/pe_array.sv
rtl/output_capture.sv
rtl/matmul_4x4_systolic.sv
verification/matmul_assertions.sv
verification/matmul_tb.sv
